// ==== hdmiTx.f ====
+incdir+tb
logic/hdmiTimingPkg.sv
logic/hdmiCodingPkg.sv
logic/tmdsEncoder.sv
logic/terc4Encoder.sv
logic/rasterTiming.sv
logic/periodScheduler.sv
logic/packetBch.sv
logic/videoChannels.sv
logic/symbolMux.sv
logic/hdmiTxCore.sv
tb/hdmiTxCoreTb.sv

// ==== logic/hdmiCodingPkg.sv ====
//////////////////////////////////////////////////
// symbol codes and the one fixed AVI infoframe packet
// pixel colors are 5 bits, expanded to 8 in the video path
//////////////////////////////////////////////////
package hdmiCodingPkg;
	typedef logic [9:0] tmdsSymbol;

	typedef struct packed {
		tmdsSymbol ch2; // red
		tmdsSymbol ch1; // green
		tmdsSymbol ch0; // blue
	} tmdsSymbols;

	typedef logic [3:0] nibble;

	typedef struct packed {
		nibble ch2;
		nibble ch1;
		nibble ch0;
	} islandNibbles;

	typedef struct packed {
		logic sha; // adds one more base step
		logic dak; // low bit of the 6-bit base
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} pixelWord;

	// indexed by the control pair {c1, c0}
	localparam logic [3:0][9:0] ctlCode = {
		10'b1010101011,
		10'b0101010100,
		10'b0010101011,
		10'b1101010100
	};

	localparam tmdsSymbol videoGuardCode = 10'b1011001100;
	localparam tmdsSymbol dataGuardCode = 10'b0100110011;

	//////////////////////////////////////////////////
	// AVI infoframe, version 2, RGB, no scan info
	localparam logic [23:0] aviHeader = 24'h0D0282;
	localparam logic [3:0][55:0] aviSubpacket = {
		56'h00000000000000,
		56'h00000000000000,
		56'h0501000005bf00,
		56'h0000010019107b // subpacket 0, checksum in the low byte
	};

	localparam logic [7:0] bchFeedback = 8'hC1; // x^8 + x^7 + x^6 + 1 taps
endpackage

// ==== logic/hdmiTimingPkg.sv ====
//////////////////////////////////////////////////
// raster geometry defaults suit 640x480 in a 768x528 frame
// island layout constants follow the HDMI data island format
//////////////////////////////////////////////////
package hdmiTimingPkg;
	typedef logic [9:0] coord; // pixel or line index

	typedef struct packed {
		coord column;
		coord row;
		logic hSync;
		logic vSync;
		logic drawArea;
	} rasterState;

	typedef struct packed {
		logic [3:0] preamble; // red pair in 3:2, green pair in 1:0
		logic videoGuard;
		logic dataGuard;
		logic island; // a packet bit is on the wire
		logic loadPacket; // one cycle, first leading guard column
		logic firstData;
		logic parity; // last four packet cycles
		logic headerParity; // packet cycles from 24 on
	} periodCtl;

	localparam int defaultDisplayWidth = 640;
	localparam int defaultDisplayHeight = 480;
	localparam int defaultFullWidth = 768;
	localparam int defaultFullHeight = 528;
	localparam int defaultHFrontPorch = 16;
	localparam int defaultHSync = 96;
	localparam int defaultVFrontPorch = 10;
	localparam int defaultVSync = 2;

	localparam int islandLead = 4; // columns after the front porch
	localparam int dataPreamble = 8;
	localparam int guardLength = 2;
	localparam int packetCycles = 32;
	localparam int headerDataCycles = 24;
	localparam int subpacketDataCycles = 28;
	localparam int videoPreamble = 8;
endpackage

// ==== logic/hdmiTxCore.sv ====
//////////////////////////////////////////////////
// pixel for column/row is expected in the same cycle
// symbols come out three pixclk later, no serializer here
//////////////////////////////////////////////////
`timescale 1ns/100ps

module hdmiTxCore #(
	parameter int displayWidth = hdmiTimingPkg::defaultDisplayWidth,
	parameter int displayHeight = hdmiTimingPkg::defaultDisplayHeight,
	parameter int fullWidth = hdmiTimingPkg::defaultFullWidth,
	parameter int fullHeight = hdmiTimingPkg::defaultFullHeight,
	parameter int hFrontPorch = hdmiTimingPkg::defaultHFrontPorch,
	parameter int hSyncWidth = hdmiTimingPkg::defaultHSync,
	parameter int vFrontPorch = hdmiTimingPkg::defaultVFrontPorch,
	parameter int vSyncWidth = hdmiTimingPkg::defaultVSync
) (
	input logic pixclk,
	input logic reset,
	input hdmiCodingPkg::pixelWord pixel,
	output hdmiTimingPkg::coord column,
	output hdmiTimingPkg::coord row,
	output hdmiCodingPkg::tmdsSymbols symbols
);
	hdmiTimingPkg::rasterState raster;
	hdmiTimingPkg::periodCtl ctl;
	hdmiCodingPkg::islandNibbles nibbles;
	hdmiCodingPkg::tmdsSymbols videoSymbols;

	rasterTiming #(.displayWidth(displayWidth), .displayHeight(displayHeight),
		.fullWidth(fullWidth), .fullHeight(fullHeight), .hFrontPorch(hFrontPorch),
		.hSyncWidth(hSyncWidth), .vFrontPorch(vFrontPorch), .vSyncWidth(vSyncWidth))
		timing (.pixclk, .reset, .raster, .column, .row);

	periodScheduler #(.fullWidth(fullWidth), .displayWidth(displayWidth),
		.hFrontPorch(hFrontPorch)) scheduler (.pixclk, .reset, .column, .ctl);

	packetBch packet (.pixclk, .reset, .ctl, .raster, .nibbles);

	videoChannels channels (.pixclk, .pixel, .raster, .ctl, .symbols(videoSymbols));

	symbolMux outMux (.pixclk, .ctl, .nibbles, .video(videoSymbols), .symbols);
endmodule

// ==== logic/packetBch.sv ====
//////////////////////////////////////////////////
// sends the same AVI infoframe in every island
// nibbles follow the registered ctl and raster in the same cycle
//////////////////////////////////////////////////
`timescale 1ns/100ps

module packetBch (
	input logic pixclk,
	input logic reset,
	input hdmiTimingPkg::periodCtl ctl,
	input hdmiTimingPkg::rasterState raster,
	output hdmiCodingPkg::islandNibbles nibbles
);
	logic [23:0] header; // shifts out lsb first
	logic [3:0][55:0] subpacket; // two bits per cycle each
	logic [7:0] headerBch;
	logic [3:0][7:0] subBch;
	logic headerBit;

	// one BCH step for a single data bit
	function automatic logic [7:0] bchStep(input logic [7:0] code, input logic dataBit);
		return {code[6:0], 1'b0} ^ ((code[7] ^ dataBit) ? hdmiCodingPkg::bchFeedback : 8'h00);
	endfunction

	//////////////////////////////////////////////////
	// packet registers and parity
	always_ff @(posedge pixclk) begin
		if (reset) begin
			headerBch <= '0;
			subBch <= '0;
		end else if (ctl.loadPacket) begin
			header <= hdmiCodingPkg::aviHeader;
			subpacket <= hdmiCodingPkg::aviSubpacket;
			headerBch <= '0;
			subBch <= '0;
		end else if (ctl.island) begin
			if (ctl.headerParity) begin
				headerBch <= {headerBch[6:0], 1'b0}; // parity shifts out top first
			end else begin
				headerBch <= bchStep(headerBch, header[0]);
				header <= {1'b0, header[23:1]};
			end
			for (int j = 0; j < 4; j++) begin
				if (ctl.parity) begin
					subBch[j] <= {subBch[j][5:0], 2'b00};
				end else begin
					subBch[j] <= bchStep(bchStep(subBch[j], subpacket[j][0]), subpacket[j][1]);
					subpacket[j] <= {2'b00, subpacket[j][55:2]};
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// island nibbles
	always_comb begin
		headerBit = ctl.headerParity ? headerBch[7] : header[0];
		if (ctl.dataGuard)
			nibbles.ch0 = {2'b11, raster.vSync, raster.hSync};
		else
			nibbles.ch0 = {~ctl.firstData, headerBit, raster.vSync, raster.hSync};
		for (int j = 0; j < 4; j++) begin
			nibbles.ch1[j] = ctl.parity ? subBch[j][7] : subpacket[j][0]; // even bits
			nibbles.ch2[j] = ctl.parity ? subBch[j][6] : subpacket[j][1]; // odd bits
		end
	end
endmodule

// ==== logic/periodScheduler.sv ====
//////////////////////////////////////////////////
// one data island per line, placed after the front porch
//////////////////////////////////////////////////
`timescale 1ns/100ps

module periodScheduler #(
	parameter int fullWidth = hdmiTimingPkg::defaultFullWidth,
	parameter int displayWidth = hdmiTimingPkg::defaultDisplayWidth,
	parameter int hFrontPorch = hdmiTimingPkg::defaultHFrontPorch
) (
	input logic pixclk,
	input logic reset,
	input hdmiTimingPkg::coord column,
	output hdmiTimingPkg::periodCtl ctl
);
	localparam int islandStart = displayWidth + hFrontPorch + hdmiTimingPkg::islandLead;
	localparam int leadGuardStart = islandStart + hdmiTimingPkg::dataPreamble;
	localparam int packetStart = leadGuardStart + hdmiTimingPkg::guardLength;
	localparam int trailGuardStart = packetStart + hdmiTimingPkg::packetCycles;
	localparam int islandEnd = trailGuardStart + hdmiTimingPkg::guardLength;
	localparam int videoGuardStart = fullWidth - hdmiTimingPkg::guardLength;
	localparam int videoPreStart = videoGuardStart - hdmiTimingPkg::videoPreamble;

	logic [3:0] preamble;
	logic videoGuard;
	logic dataGuard;
	logic island;
	logic loadPacket;
	logic [4:0] packetCount; // packet cycle k

	always_ff @(posedge pixclk) begin
		if (reset) begin
			preamble <= '0;
			videoGuard <= 1'b0;
			dataGuard <= 1'b0;
			island <= 1'b0;
			loadPacket <= 1'b0;
			packetCount <= '0;
		end else begin
			if (column >= islandStart && column < leadGuardStart)
				preamble <= 4'b0101; // data island preamble
			else if (column >= videoPreStart && column < videoGuardStart)
				preamble <= 4'b0001; // video preamble
			else
				preamble <= 4'b0000;
			videoGuard <= column >= videoGuardStart;
			dataGuard <= (column >= leadGuardStart && column < packetStart)
				|| (column >= trailGuardStart && column < islandEnd);
			island <= column >= packetStart && column < trailGuardStart;
			loadPacket <= column == leadGuardStart;
			packetCount <= island ? packetCount + 5'd1 : 5'd0; // wraps to 0 after cycle 31
		end
	end

	always_comb begin
		ctl.preamble = preamble;
		ctl.videoGuard = videoGuard;
		ctl.dataGuard = dataGuard;
		ctl.island = island;
		ctl.loadPacket = loadPacket;
		ctl.firstData = island && packetCount == 5'd0;
		ctl.parity = island && packetCount >= 5'(hdmiTimingPkg::subpacketDataCycles);
		ctl.headerParity = island && packetCount >= 5'(hdmiTimingPkg::headerDataCycles);
	end
endmodule

// ==== logic/rasterTiming.sv ====
//////////////////////////////////////////////////
// flags lag the raw counters by one pixclk
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rasterTiming #(
	parameter int displayWidth = hdmiTimingPkg::defaultDisplayWidth,
	parameter int displayHeight = hdmiTimingPkg::defaultDisplayHeight,
	parameter int fullWidth = hdmiTimingPkg::defaultFullWidth,
	parameter int fullHeight = hdmiTimingPkg::defaultFullHeight,
	parameter int hFrontPorch = hdmiTimingPkg::defaultHFrontPorch,
	parameter int hSyncWidth = hdmiTimingPkg::defaultHSync,
	parameter int vFrontPorch = hdmiTimingPkg::defaultVFrontPorch,
	parameter int vSyncWidth = hdmiTimingPkg::defaultVSync
) (
	input logic pixclk,
	input logic reset,
	output hdmiTimingPkg::rasterState raster,
	output hdmiTimingPkg::coord column,
	output hdmiTimingPkg::coord row
);
	localparam int hSyncStart = displayWidth + hFrontPorch;
	localparam int vSyncStart = displayHeight + vFrontPorch;

	always_ff @(posedge pixclk) begin
		if (reset) begin
			column <= '0;
			row <= '0;
			raster <= '0;
		end else begin
			column <= (column == hdmiTimingPkg::coord'(fullWidth - 1)) ? '0 : column + 1'b1;
			if (column == hdmiTimingPkg::coord'(fullWidth - 1)) begin // end of line
				row <= (row == hdmiTimingPkg::coord'(fullHeight - 1)) ? '0 : row + 1'b1;
			end
			raster.column <= column;
			raster.row <= row;
			raster.hSync <= (column >= hSyncStart) && (column < hSyncStart + hSyncWidth);
			raster.vSync <= (row >= vSyncStart) && (row < vSyncStart + vSyncWidth);
			raster.drawArea <= (column < displayWidth) && (row < displayHeight);
		end
	end
endmodule

// ==== logic/symbolMux.sv ====
//////////////////////////////////////////////////
// output symbols are registered, one per channel
//////////////////////////////////////////////////
`timescale 1ns/100ps

module symbolMux (
	input logic pixclk,
	input hdmiTimingPkg::periodCtl ctl,
	input hdmiCodingPkg::islandNibbles nibbles,
	input hdmiCodingPkg::tmdsSymbols video,
	output hdmiCodingPkg::tmdsSymbols symbols
);
	logic islandDly; // flags aligned to encoder outputs
	logic dataGuardDly;
	logic videoGuardDly;
	hdmiCodingPkg::tmdsSymbol terc2;
	hdmiCodingPkg::tmdsSymbol terc1;
	hdmiCodingPkg::tmdsSymbol terc0;

	terc4Encoder ch2Terc (.pixclk, .data(nibbles.ch2), .symbol(terc2));
	terc4Encoder ch1Terc (.pixclk, .data(nibbles.ch1), .symbol(terc1));
	terc4Encoder ch0Terc (.pixclk, .data(nibbles.ch0), .symbol(terc0));

	always_ff @(posedge pixclk) begin
		islandDly <= ctl.island;
		dataGuardDly <= ctl.dataGuard;
		videoGuardDly <= ctl.videoGuard;
	end

	always_ff @(posedge pixclk) begin
		symbols.ch2 <= videoGuardDly ? hdmiCodingPkg::videoGuardCode
			: dataGuardDly ? hdmiCodingPkg::dataGuardCode
			: islandDly ? terc2 : video.ch2;
		symbols.ch1 <= (videoGuardDly || dataGuardDly) ? hdmiCodingPkg::dataGuardCode
			: islandDly ? terc1 : video.ch1;
		symbols.ch0 <= videoGuardDly ? hdmiCodingPkg::videoGuardCode
			: (dataGuardDly || islandDly) ? terc0 : video.ch0; // guard keeps sync on ch0
	end
endmodule

// ==== logic/terc4Encoder.sv ====
//////////////////////////////////////////////////
// one cycle from nibble to symbol
//////////////////////////////////////////////////
`timescale 1ns/100ps

module terc4Encoder (
	input logic pixclk,
	input hdmiCodingPkg::nibble data,
	output hdmiCodingPkg::tmdsSymbol symbol
);
	always_ff @(posedge pixclk) begin
		case (data)
			4'h0: symbol <= 10'b1010011100;
			4'h1: symbol <= 10'b1001100011;
			4'h2: symbol <= 10'b1011100100;
			4'h3: symbol <= 10'b1011100010;
			4'h4: symbol <= 10'b0101110001;
			4'h5: symbol <= 10'b0100011110;
			4'h6: symbol <= 10'b0110001110;
			4'h7: symbol <= 10'b0100111100;
			4'h8: symbol <= 10'b1011001100;
			4'h9: symbol <= 10'b0100111001;
			4'hA: symbol <= 10'b0110011100;
			4'hB: symbol <= 10'b1011000110;
			4'hC: symbol <= 10'b1010001110;
			4'hD: symbol <= 10'b1001110001;
			4'hE: symbol <= 10'b0101100011;
			default: symbol <= 10'b1011000011;
		endcase
	end
endmodule

// ==== logic/tmdsEncoder.sv ====
//////////////////////////////////////////////////
// disparity restarts from 0 at each active line
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tmdsEncoder (
	input logic pixclk,
	input logic [7:0] videoData,
	input logic [1:0] ctlData,
	input logic videoEnable,
	output hdmiCodingPkg::tmdsSymbol symbol
);
	logic [3:0] ones;
	logic useXnor;
	logic [8:0] qm; // transition minimized word
	logic [3:0] balance; // ones minus zeros, halved
	logic [3:0] disparity;
	logic sameSign;
	logic evenCase;
	logic invert;
	logic [3:0] step;
	logic [3:0] nextDisparity;

	always_comb begin
		ones = 4'($countones(videoData));
		useXnor = (ones > 4'd4) || (ones == 4'd4 && !videoData[0]);
		qm[0] = videoData[0];
		for (int i = 1; i < 8; i++)
			qm[i] = qm[i - 1] ^ videoData[i] ^ useXnor;
		qm[8] = ~useXnor;
		balance = 4'($countones(qm[7:0])) - 4'd4;
		sameSign = balance[3] == disparity[3];
		evenCase = (balance == 4'd0) || (disparity == 4'd0);
		invert = evenCase ? ~qm[8] : sameSign;
		step = balance - {3'b000, (qm[8] ^ ~sameSign) & ~evenCase};
		nextDisparity = invert ? disparity - step : disparity + step;
	end

	always_ff @(posedge pixclk) begin
		symbol <= videoEnable ? {invert, qm[8], qm[7:0] ^ {8{invert}}}
			: hdmiCodingPkg::ctlCode[ctlData];
		disparity <= videoEnable ? nextDisparity : 4'd0;
	end
endmodule

// ==== logic/videoChannels.sv ====
//////////////////////////////////////////////////
// expanded colors span 0 to 252
//////////////////////////////////////////////////
`timescale 1ns/100ps

module videoChannels (
	input logic pixclk,
	input hdmiCodingPkg::pixelWord pixel,
	input hdmiTimingPkg::rasterState raster,
	input hdmiTimingPkg::periodCtl ctl,
	output hdmiCodingPkg::tmdsSymbols symbols
);
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	hdmiCodingPkg::tmdsSymbol redSymbol;
	hdmiCodingPkg::tmdsSymbol greenSymbol;
	hdmiCodingPkg::tmdsSymbol blueSymbol;

	// base is color*2 + dak, then base*3, plus base once more with sha
	function automatic logic [7:0] expand(input logic [4:0] color, input logic dak,
			input logic sha);
		logic [7:0] base;
		base = {2'b00, color, dak};
		return base * 8'd3 + (sha ? base : 8'd0);
	endfunction

	always_ff @(posedge pixclk) begin // lines up with the raster flags
		red <= expand(pixel.red, pixel.dak, pixel.sha);
		green <= expand(pixel.green, pixel.dak, pixel.sha);
		blue <= expand(pixel.blue, pixel.dak, pixel.sha);
	end

	tmdsEncoder redEncoder (.pixclk, .videoData(red), .ctlData(ctl.preamble[3:2]),
		.videoEnable(raster.drawArea), .symbol(redSymbol));
	tmdsEncoder greenEncoder (.pixclk, .videoData(green), .ctlData(ctl.preamble[1:0]),
		.videoEnable(raster.drawArea), .symbol(greenSymbol));
	tmdsEncoder blueEncoder (.pixclk, .videoData(blue), .ctlData({raster.vSync, raster.hSync}),
		.videoEnable(raster.drawArea), .symbol(blueSymbol));

	assign symbols = {redSymbol, greenSymbol, blueSymbol};
endmodule

// ==== tb/txModel.svh ====
//////////////////////////////////////////////////
// reference model, included inside the testbench module
// packet content is the fixed AVI infoframe of the coding package
//////////////////////////////////////////////////
`ifndef TX_MODEL_SVH
`define TX_MODEL_SVH

// control codes indexed by {c1, c0}
localparam logic [9:0] ctlTable [4] = '{10'b1101010100, 10'b0010101011,
	10'b0101010100, 10'b1010101011};
localparam logic [9:0] terc4Table [16] = '{
	10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
	10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
	10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
	10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011};
localparam logic [9:0] videoGuardSym = 10'b1011001100;
localparam logic [9:0] dataGuardSym = 10'b0100110011;
localparam logic [7:0] bchMask = 8'b1100_0001; // taps at bits 7, 6 and 0

function automatic logic [31:0] lcgNext(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// base is color*2 + dak, four times base with sha, else three times
function automatic logic [7:0] colorLevel(input logic [4:0] color, input logic dak,
		input logic sha);
	int base;
	base = color * 2 + dak;
	return 8'(sha ? base * 4 : base * 3);
endfunction

function automatic logic [7:0] tmdsDecode(input hdmiCodingPkg::tmdsSymbol sym);
	logic [7:0] word;
	logic [7:0] data;
	word = sym[9] ? ~sym[7:0] : sym[7:0]; // undo the inversion
	data[0] = word[0];
	for (int i = 1; i < 8; i++)
		data[i] = sym[8] ? word[i] ^ word[i - 1] : ~(word[i] ^ word[i - 1]);
	return data;
endfunction

function automatic hdmiCodingPkg::nibble terc4Decode(input hdmiCodingPkg::tmdsSymbol sym);
	hdmiCodingPkg::nibble found;
	found = 'x; // stays unknown when no code matches
	for (int i = 0; i < 16; i++)
		if (terc4Table[i] == sym)
			found = 4'(i);
	return found;
endfunction

// parity byte over the first count bits, lsb first
function automatic logic [7:0] bchParity(input logic [55:0] bits, input int count);
	logic [7:0] code;
	logic top;
	code = '0;
	for (int i = 0; i < count; i++) begin
		top = code[7] ^ bits[i];
		code = {code[6:0], 1'b0};
		if (top)
			code = code ^ bchMask;
	end
	return code;
endfunction

// expected nibbles of packet cycle k
function automatic hdmiCodingPkg::islandNibbles packetNibbles(input int k, input logic vs,
		input logic hs);
	hdmiCodingPkg::islandNibbles want;
	logic [7:0] headerCode;
	logic [7:0] subCode;
	logic [55:0] sub;
	headerCode = bchParity({32'd0, hdmiCodingPkg::aviHeader}, 24);
	want.ch0 = {k != 0, (k < 24) ? hdmiCodingPkg::aviHeader[k] : headerCode[31 - k], vs, hs};
	for (int j = 0; j < 4; j++) begin
		sub = hdmiCodingPkg::aviSubpacket[j];
		subCode = bchParity(sub, 56);
		want.ch1[j] = (k < 28) ? sub[2 * k] : subCode[7 - 2 * (k - 28)]; // even bits
		want.ch2[j] = (k < 28) ? sub[2 * k + 1] : subCode[6 - 2 * (k - 28)];
	end
	return want;
endfunction

`endif

// ==== tb/hdmiTxCoreTb.sv ====
//////////////////////////////////////////////////
// small raster with two full frames checked column by column
//////////////////////////////////////////////////
`timescale 1ns/100ps

module hdmiTxCoreTb;
	localparam int displayWidth = 64;
	localparam int displayHeight = 4;
	localparam int fullWidth = 144;
	localparam int fullHeight = 6;
	localparam int hFrontPorch = 8;
	localparam int hSyncWidth = 16;
	localparam int vFrontPorch = 1;
	localparam int vSyncWidth = 1;
	localparam int clockPeriod = 40;
	localparam int runCycles = 2 * fullWidth * fullHeight; // two frames

	//////////////////////////////////////////////////
	// line layout
	localparam int hSyncStart = displayWidth + hFrontPorch;
	localparam int vSyncStart = displayHeight + vFrontPorch;
	localparam int islandStart = hSyncStart + 4;
	localparam int leadGuardStart = islandStart + 8;
	localparam int packetStart = leadGuardStart + 2;
	localparam int trailGuardStart = packetStart + 32;
	localparam int islandEnd = trailGuardStart + 2;
	localparam int videoPreStart = fullWidth - 10;
	localparam int videoGuardStart = fullWidth - 2;

	typedef struct packed {
		hdmiTimingPkg::coord column;
		hdmiTimingPkg::coord row;
		hdmiCodingPkg::pixelWord pixel;
	} sample;

	logic pixclk;
	logic reset;
	hdmiCodingPkg::pixelWord pixel;
	hdmiTimingPkg::coord column;
	hdmiTimingPkg::coord row;
	hdmiCodingPkg::tmdsSymbols symbols;
	sample expectQ[$]; // three cycles of pipeline in flight
	sample current;
	logic [31:0] rngState;
	int packetChecks;
	hdmiTimingPkg::coord modelColumn; // raster position from the wrap rule
	hdmiTimingPkg::coord modelRow;

	`include "txModel.svh"

	hdmiTxCore #(.displayWidth(displayWidth), .displayHeight(displayHeight),
		.fullWidth(fullWidth), .fullHeight(fullHeight), .hFrontPorch(hFrontPorch),
		.hSyncWidth(hSyncWidth), .vFrontPorch(vFrontPorch), .vSyncWidth(vSyncWidth))
		uut (.pixclk, .reset, .pixel, .column, .row, .symbols);

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkSymbol(input hdmiCodingPkg::tmdsSymbol expected, actual,
			input string what);
		if (actual !== expected)
			stopRun($sformatf("ERROR at %0t ns: %s expected %b got %b", $time, what,
				expected, actual));
	endtask

	task automatic checkPixel(input logic [7:0] expected, actual, input string what);
		if (actual !== expected)
			stopRun($sformatf("ERROR at %0t ns: %s expected %0d got %0d", $time, what,
				expected, actual));
	endtask

	task automatic checkNibble(input hdmiCodingPkg::nibble expected, actual,
			input string what);
		if (actual !== expected)
			stopRun($sformatf("ERROR at %0t ns: %s expected %b got %b", $time, what,
				expected, actual));
	endtask

	task automatic checkCoord(input hdmiTimingPkg::coord expected, actual,
			input string what);
		if (actual !== expected)
			stopRun($sformatf("ERROR at %0t ns: %s expected %0d got %0d", $time, what,
				expected, actual));
	endtask

	//////////////////////////////////////////////////
	// one output column against the model
	task automatic checkColumn(input sample s, input hdmiCodingPkg::tmdsSymbols got);
		int c;
		int r;
		logic hs;
		logic vs;
		string at;
		hdmiCodingPkg::islandNibbles want;
		c = s.column;
		r = s.row;
		hs = c >= hSyncStart && c < hSyncStart + hSyncWidth;
		vs = r >= vSyncStart && r < vSyncStart + vSyncWidth;
		at = $sformatf("column %0d row %0d", c, r);
		if (c < displayWidth && r < displayHeight) begin
			checkPixel(colorLevel(s.pixel.red, s.pixel.dak, s.pixel.sha),
				tmdsDecode(got.ch2), {"red ", at});
			checkPixel(colorLevel(s.pixel.green, s.pixel.dak, s.pixel.sha),
				tmdsDecode(got.ch1), {"green ", at});
			checkPixel(colorLevel(s.pixel.blue, s.pixel.dak, s.pixel.sha),
				tmdsDecode(got.ch0), {"blue ", at});
		end else if (c >= videoGuardStart) begin
			checkSymbol(videoGuardSym, got.ch2, {"video guard ch2 ", at});
			checkSymbol(dataGuardSym, got.ch1, {"video guard ch1 ", at});
			checkSymbol(videoGuardSym, got.ch0, {"video guard ch0 ", at});
		end else if (c >= videoPreStart) begin // preamble 0001
			checkSymbol(ctlTable[0], got.ch2, {"video preamble ch2 ", at});
			checkSymbol(ctlTable[1], got.ch1, {"video preamble ch1 ", at});
			checkSymbol(ctlTable[{vs, hs}], got.ch0, {"video preamble ch0 ", at});
		end else if (c >= islandStart && c < leadGuardStart) begin // preamble 0101
			checkSymbol(ctlTable[1], got.ch2, {"data preamble ch2 ", at});
			checkSymbol(ctlTable[1], got.ch1, {"data preamble ch1 ", at});
			checkSymbol(ctlTable[{vs, hs}], got.ch0, {"data preamble ch0 ", at});
		end else if ((c >= leadGuardStart && c < packetStart)
				|| (c >= trailGuardStart && c < islandEnd)) begin
			checkSymbol(dataGuardSym, got.ch2, {"data guard ch2 ", at});
			checkSymbol(dataGuardSym, got.ch1, {"data guard ch1 ", at});
			checkNibble({2'b11, vs, hs}, terc4Decode(got.ch0), {"data guard ch0 ", at});
		end else if (c >= packetStart && c < trailGuardStart) begin
			want = packetNibbles(c - packetStart, vs, hs);
			checkNibble(want.ch2, terc4Decode(got.ch2), {"packet ch2 ", at});
			checkNibble(want.ch1, terc4Decode(got.ch1), {"packet ch1 ", at});
			checkNibble(want.ch0, terc4Decode(got.ch0), {"packet ch0 ", at});
			packetChecks++;
		end else begin // plain blanking
			checkSymbol(ctlTable[0], got.ch2, {"blanking ch2 ", at});
			checkSymbol(ctlTable[0], got.ch1, {"blanking ch1 ", at});
			checkSymbol(ctlTable[{vs, hs}], got.ch0, {"blanking ch0 ", at});
		end
	endtask

	initial begin
		pixclk = 1'b0;
		forever #(clockPeriod / 2) pixclk = ~pixclk;
	end

	initial begin // watchdog for two frames plus some slack
		#((runCycles + 50) * clockPeriod);
		stopRun("timeout: the run did not finish within two frames");
	end

	initial begin
		reset = 1'b1;
		pixel = '0;
		rngState = 32'ha254;
		packetChecks = 0;
		modelColumn = '0;
		modelRow = '0;
		repeat (3) @(negedge pixclk);
		reset = 1'b0;
		for (int n = 0; n < runCycles + 3; n++) begin
			checkCoord(modelColumn, column, "column port");
			checkCoord(modelRow, row, "row port");
			if (expectQ.size() == 3)
				checkColumn(expectQ.pop_front(), symbols); // output for three cycles back
			rngState = lcgNext(rngState);
			pixel = hdmiCodingPkg::pixelWord'(rngState[30:14]);
			current = {modelColumn, modelRow, pixel};
			expectQ.push_back(current);
			if (modelColumn == fullWidth - 1) begin
				modelColumn = '0;
				modelRow = (modelRow == fullHeight - 1) ? '0 : modelRow + 1'b1;
			end else begin
				modelColumn = modelColumn + 1'b1;
			end
			@(negedge pixclk);
		end
		if (packetChecks != 2 * fullHeight * 32)
			stopRun("not every packet cycle of the two frames was seen on the output");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end
endmodule
